// File: sim.f
+incdir+verification
rtl/icachePkg.sv
rtl/lookupIf.sv
rtl/setStore.sv
rtl/fetchFront.sv
rtl/lookupUnit.sv
rtl/icacheTop.sv
verification/icacheTb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - rtl/icachePkg.sv
      - rtl/lookupIf.sv
      - rtl/setStore.sv
      - rtl/fetchFront.sv
      - rtl/lookupUnit.sv
      - rtl/icacheTop.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/icacheTb.sv

// File: verification/icacheTbTasks.svh
`ifndef ICACHE_TB_TASKS_SVH
`define ICACHE_TB_TASKS_SVH

// reference copy of the tag side of the cache
logic [icachePkg::NUM_WAYS-1:0] refValid [2 ** INDEX_BITS];
icachePkg::lineTagT refTag [2 ** INDEX_BITS][icachePkg::NUM_WAYS];
icachePkg::ageT refAge [2 ** INDEX_BITS];

// each memory word holds its own byte address inverted
function automatic icachePkg::lineT memLine(input icachePkg::addrT addr);
    icachePkg::lineT line;
    for (int w = 0; w < 4; w++) begin
        line[w * 32 +: 32] = ~{addr[31:4], 2'(w), 2'b00};
    end
    return line;
endfunction

task automatic applyReset();
    refValid = '{default: '0};
    refAge = '{default: '0};
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
endtask

// record one completed fetch and tell whether it hits
task automatic modelAccess(input icachePkg::addrT addr, output bit hit);
    int s;
    int way;
    icachePkg::ageT age;
    s = int'(addr[icachePkg::OFFSET_BITS +: INDEX_BITS]);
    age = refAge[s];
    way = -1;
    for (int w = 0; w < icachePkg::NUM_WAYS; w++) begin
        if (refValid[s][w] && refTag[s][w] == addr[31:icachePkg::OFFSET_BITS]) begin
            way = w;
        end
    end
    hit = way >= 0;
    if (!hit) begin
        // follow the age bits to the less recently used side
        way = age[0] ? int'(!age[1]) : 2 + int'(!age[2]);
        refValid[s][way] = 1'b1;
        refTag[s][way] = addr[31:icachePkg::OFFSET_BITS];
    end
    age[0] = way[1];
    age[way[1] ? 2 : 1] = way[0];
    refAge[s] = age;
endtask

task automatic checkInst(input icachePkg::instT got, input icachePkg::instT exp,
                         input string what);
    if (got !== exp) begin
        reportFailure($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
                                $time, what, got, exp));
    end
endtask

task automatic checkAddr(input icachePkg::addrT got, input icachePkg::addrT exp,
                         input string what);
    if (got !== exp) begin
        reportFailure($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
                                $time, what, got, exp));
    end
endtask

task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        reportFailure($sformatf("MISMATCH at %0d ns: %s got %b expected %b",
                                $time, what, got, exp));
    end
endtask

// pair words follow address bit 3 and inst0Valid follows bit 2
task automatic checkPair(input icachePkg::addrT addr);
    checkBit(fetchValid, 1'b1, "fetchValid");
    checkAddr(fetchPc, addr & ~icachePkg::addrT'(4), "fetchPc");
    checkInst(inst0, ~{addr[31:3], 3'b000}, "inst0");
    checkInst(inst1, ~{addr[31:3], 3'b100}, "inst1");
    checkBit(inst0Valid, !addr[2], "inst0Valid");
endtask

// one fetch with the result expected one cycle later or on the refill
task automatic doFetch(input icachePkg::addrT addr);
    bit hit;
    int cycles;
    modelAccess(addr, hit);
    fetchReq = 1'b1;
    fetchAddr = addr;
    @(posedge clk);
    #1;
    fetchReq = 1'b0;
    @(negedge clk);
    checkBit(memReqValid, !hit, "memReqValid in lookup cycle");
    checkBit(stall, !hit, "stall in lookup cycle");
    if (hit) begin
        checkPair(addr);
    end else begin
        checkAddr(memReqAddr, addr & ~icachePkg::addrT'(15), "memReqAddr");
        cycles = 0;
        while (!fetchValid) begin
            checkBit(stall, 1'b1, "stall while waiting for refill");
            cycles = cycles + 1;
            if (cycles > RESP_LIMIT) begin
                reportFailure("miss was never answered with fetchValid");
            end
            @(negedge clk);
        end
        checkBit(memRespValid, 1'b1, "refill fetchValid outside response cycle");
        checkBit(stall, 1'b1, "stall in response cycle");
        checkPair(addr);
        @(negedge clk);
        checkBit(stall, 1'b0, "stall after refill");
    end
    @(posedge clk);
    #1;
endtask

`endif

// File: verification/icacheTb.sv
`timescale 1ns/1ps

module icacheTb;

    localparam int INDEX_BITS = 6;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;
    // a refill never takes longer than this many cycles
    localparam int RESP_LIMIT = 20;

    logic clk;
    logic rst;
    logic fetchReq;
    icachePkg::addrT fetchAddr;
    logic flush;
    logic memRespValid;
    icachePkg::lineT memRespLine;
    logic stall;
    logic fetchValid;
    icachePkg::addrT fetchPc;
    icachePkg::instT inst0;
    icachePkg::instT inst1;
    logic inst0Valid;
    logic memReqValid;
    icachePkg::addrT memReqAddr;

    integer seed = 32'hfa5b4077;

    icacheTop #(
        .INDEX_BITS (INDEX_BITS)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "icacheTbTasks.svh"

    // memory answers each line request after 1 to 6 cycles
    initial begin
        int delay;
        icachePkg::addrT reqAddr;
        memRespValid = 1'b0;
        memRespLine = '0;
        forever begin
            @(negedge clk);
            if (memReqValid) begin
                reqAddr = memReqAddr;
                delay = 1 + int'($unsigned($random(seed)) % 6);
                repeat (delay) @(posedge clk);
                #1;
                memRespValid = 1'b1;
                memRespLine = memLine(reqAddr);
                @(posedge clk);
                #1;
                memRespValid = 1'b0;
            end
        end
    end

    task automatic coldMissThenHit();
        doFetch(32'h0000_1008);
        doFetch(32'h0000_1008);
    endtask

    task automatic pairSelection();
        for (int i = 0; i < 4; i++) begin
            doFetch(32'h0000_2a70 + icachePkg::addrT'(4 * i));
        end
    endtask

    task automatic replacement();
        // lines 0 to 3 fill set 20 and reuse of 0 and 2 leaves line 1 for line 4 to evict
        int order [12] = '{0, 1, 2, 3, 0, 2, 4, 0, 2, 3, 4, 1};
        foreach (order[i]) begin
            doFetch(32'h0010_0140 + icachePkg::addrT'(order[i] << 10));
        end
    endtask

    task automatic flushDuringMiss();
        bit sawResp;
        int cycles;
        fetchReq = 1'b1;
        fetchAddr = 32'h0000_3a40;
        @(posedge clk);
        #1;
        fetchReq = 1'b0;
        @(negedge clk);
        checkBit(memReqValid, 1'b1, "memReqValid before flush");
        @(posedge clk);
        #1;
        flush = 1'b1;
        sawResp = 1'b0;
        cycles = 0;
        while (!sawResp) begin
            @(negedge clk);
            checkBit(fetchValid, 1'b0, "fetchValid of flushed request");
            checkBit(stall, 1'b1, "stall until discarded response");
            sawResp = memRespValid;
            cycles = cycles + 1;
            if (cycles > RESP_LIMIT) begin
                reportFailure("flushed miss was never answered by memory");
            end
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
        @(negedge clk);
        checkBit(stall, 1'b0, "stall after discarded response");
        @(posedge clk);
        #1;
        // the discarded line must not have been written
        doFetch(32'h0000_3a40);
    endtask

    task automatic backToBackHits();
        icachePkg::addrT addrs [4] = '{32'h0000_1004, 32'h0000_2a7c,
                                       32'h0000_100c, 32'h0000_2a70};
        bit hit;
        for (int i = 0; i <= 4; i++) begin
            fetchReq = i < 4;
            if (i < 4) begin
                fetchAddr = addrs[i];
                modelAccess(addrs[i], hit);
            end
            @(negedge clk);
            checkBit(stall, 1'b0, "stall during hit burst");
            checkBit(memReqValid, 1'b0, "memReqValid during hit burst");
            if (i > 0) begin
                checkPair(addrs[i - 1]);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic resetClearsValid();
        applyReset();
        @(negedge clk);
        checkBit(stall | fetchValid | memReqValid, 1'b0, "outputs after reset");
        @(posedge clk);
        #1;
        // cached before the reset
        doFetch(32'h0000_1000);
    endtask

    initial begin
        rst = 1'b1;
        fetchReq = 1'b0;
        fetchAddr = '0;
        flush = 1'b0;
        applyReset();
        coldMissThenHit();
        pairSelection();
        replacement();
        flushDuringMiss();
        backToBackHits();
        resetClearsValid();
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: test sequence still running after %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: rtl/icacheTop.sv
`timescale 1ns/1ps

module icacheTop #(
    parameter int INDEX_BITS = 6
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetchReq,
    input  icachePkg::addrT     fetchAddr,
    input  logic                flush,
    input  logic                memRespValid,
    input  icachePkg::lineT     memRespLine,
    output logic                stall,
    output logic                fetchValid,
    output icachePkg::addrT     fetchPc,
    output icachePkg::instT     inst0,
    output icachePkg::instT     inst1,
    output logic                inst0Valid,
    output logic                memReqValid,
    output icachePkg::addrT     memReqAddr
);

    logic [INDEX_BITS-1:0] readIndex;
    logic writeEn;
    icachePkg::wayT writeWay;
    logic [INDEX_BITS-1:0] writeIndex;
    icachePkg::lineTagT tagWriteData;
    icachePkg::lineT lineWriteData;
    icachePkg::lineTagT tagRead [icachePkg::NUM_WAYS];
    icachePkg::lineT lineRead [icachePkg::NUM_WAYS];

    lookupIf lkIf ();

    fetchFront #(
        .INDEX_BITS (INDEX_BITS)
    ) u_fetchFront (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .fetchReq     (fetchReq),
        .fetchAddr    (fetchAddr),
        .memRespValid (memRespValid),
        .stall        (stall),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .readIndex    (readIndex),
        .lk           (lkIf.front)
    );

    setStore #(
        .INDEX_BITS (INDEX_BITS),
        .payloadT   (icachePkg::lineTagT)
    ) u_tagStore (
        .clk        (clk),
        .readIndex  (readIndex),
        .writeEn    (writeEn),
        .writeWay   (writeWay),
        .writeIndex (writeIndex),
        .writeData  (tagWriteData),
        .readData   (tagRead)
    );

    setStore #(
        .INDEX_BITS (INDEX_BITS),
        .payloadT   (icachePkg::lineT)
    ) u_lineStore (
        .clk        (clk),
        .readIndex  (readIndex),
        .writeEn    (writeEn),
        .writeWay   (writeWay),
        .writeIndex (writeIndex),
        .writeData  (lineWriteData),
        .readData   (lineRead)
    );

    lookupUnit #(
        .INDEX_BITS (INDEX_BITS)
    ) u_lookupUnit (
        .clk           (clk),
        .rst           (rst),
        .memRespLine   (memRespLine),
        .tagRead       (tagRead),
        .lineRead      (lineRead),
        .writeEn       (writeEn),
        .writeWay      (writeWay),
        .writeIndex    (writeIndex),
        .tagWriteData  (tagWriteData),
        .lineWriteData (lineWriteData),
        .fetchValid    (fetchValid),
        .fetchPc       (fetchPc),
        .inst0         (inst0),
        .inst1         (inst1),
        .inst0Valid    (inst0Valid),
        .lk            (lkIf.lookup)
    );

endmodule

// File: rtl/lookupUnit.sv
`timescale 1ns/1ps

module lookupUnit #(
    parameter int INDEX_BITS = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  icachePkg::lineT        memRespLine,
    input  icachePkg::lineTagT     tagRead [icachePkg::NUM_WAYS],
    input  icachePkg::lineT        lineRead [icachePkg::NUM_WAYS],
    output logic                   writeEn,
    output icachePkg::wayT         writeWay,
    output logic [INDEX_BITS-1:0]  writeIndex,
    output icachePkg::lineTagT     tagWriteData,
    output icachePkg::lineT        lineWriteData,
    output logic                   fetchValid,
    output icachePkg::addrT        fetchPc,
    output icachePkg::instT        inst0,
    output icachePkg::instT        inst1,
    output logic                   inst0Valid,
    lookupIf.lookup                lk
);

    localparam int NUM_SETS = 2 ** INDEX_BITS;

    logic [icachePkg::NUM_WAYS-1:0] validBits [NUM_SETS];
    icachePkg::ageT ages [NUM_SETS];

    logic [INDEX_BITS-1:0] lookupIndex;
    icachePkg::lineTagT lineTag;
    logic [icachePkg::NUM_WAYS-1:0] hitVec;
    icachePkg::wayT hitWay;
    icachePkg::wayT victimWay;
    icachePkg::ageT setAge;
    icachePkg::lineT selLine;
    logic [1:0] wordSel;

    // mark way as most recently used
    function automatic icachePkg::ageT touchAge(icachePkg::ageT age, icachePkg::wayT way);
        icachePkg::ageT result;
        result    = age;
        result[0] = way[1];
        if (!way[1]) begin
            result[1] = way[0];
        end else begin
            result[2] = way[0];
        end
        return result;
    endfunction

    assign lookupIndex = lk.lookupAddr[icachePkg::OFFSET_BITS +: INDEX_BITS];
    assign lineTag     = lk.lookupAddr[icachePkg::ADDR_BITS-1:icachePkg::OFFSET_BITS];
    assign setAge      = ages[lookupIndex];

    for (genvar w = 0; w < icachePkg::NUM_WAYS; w++) begin : g_cmp
        assign hitVec[w] = validBits[lookupIndex][w] && tagRead[w] == lineTag;
    end

    assign lk.hit = lk.lookupValid && |hitVec;

    always_comb begin
        hitWay = '0;
        for (int w = 0; w < icachePkg::NUM_WAYS; w++) begin
            if (hitVec[w]) begin
                hitWay = icachePkg::wayT'(w);
            end
        end
    end

    // walk the tree away from the recently used side
    always_comb begin
        if (setAge[0]) begin
            victimWay = setAge[1] ? 2'd0 : 2'd1;
        end else begin
            victimWay = setAge[2] ? 2'd2 : 2'd3;
        end
    end

    // refill goes to both stores at the same way and set
    assign writeEn       = lk.refillEn;
    assign writeWay      = victimWay;
    assign writeIndex    = lookupIndex;
    assign tagWriteData  = lineTag;
    assign lineWriteData = memRespLine;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                validBits[i] <= '0;
                ages[i]      <= '0;
            end
        end else if (lk.refillEn) begin
            validBits[lookupIndex][victimWay] <= 1'b1;
            ages[lookupIndex] <= touchAge(setAge, victimWay);
        end else if (lk.hit && !lk.cancel) begin
            ages[lookupIndex] <= touchAge(setAge, hitWay);
        end
    end

    // the refill line bypasses the store in its arrival cycle
    assign selLine = lk.refillEn ? memRespLine : lineRead[hitWay];
    assign wordSel = {lk.lookupAddr[3], 1'b0};

    assign inst0 = selLine[wordSel * icachePkg::WORD_BITS +: icachePkg::WORD_BITS];
    assign inst1 = selLine[(wordSel + 2'd1) * icachePkg::WORD_BITS +: icachePkg::WORD_BITS];

    assign inst0Valid = !lk.lookupAddr[2];
    assign fetchPc    = {lk.lookupAddr[icachePkg::ADDR_BITS-1:3], 1'b0, lk.lookupAddr[1:0]};
    assign fetchValid = (lk.hit && !lk.cancel) || lk.refillEn;

    // a line lives in one way only
    assert property (@(posedge clk) disable iff (rst)
        lk.lookupValid |-> $onehot0(hitVec));

    // front end keeps lookups out of the refill cycle
    assert property (@(posedge clk) disable iff (rst)
        writeEn |-> lk.refillEn && !lk.lookupValid);

endmodule

// File: rtl/fetchFront.sv
`timescale 1ns/1ps

module fetchFront #(
    parameter int INDEX_BITS = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   fetchReq,
    input  icachePkg::addrT        fetchAddr,
    input  logic                   memRespValid,
    output logic                   stall,
    output logic                   memReqValid,
    output icachePkg::addrT        memReqAddr,
    output logic [INDEX_BITS-1:0]  readIndex,
    lookupIf.front                 lk
);

    typedef enum logic [1:0] {
        sRunning,
        sRefill,
        sRecover
    } stateT;

    stateT state;
    stateT nextState;
    logic accept;
    logic missNow;

    assign accept = fetchReq && !stall && !flush;

    // the stores read this set while the request is accepted
    assign readIndex = fetchAddr[icachePkg::OFFSET_BITS +: INDEX_BITS];

    // a flushed miss asks memory for nothing
    assign missNow = state == sRunning && lk.lookupValid && !lk.hit && !flush;

    assign stall = missNow || state != sRunning;

    assign memReqValid = missNow;
    assign memReqAddr  = {lk.lookupAddr[icachePkg::ADDR_BITS-1:icachePkg::OFFSET_BITS],
                          {icachePkg::OFFSET_BITS{1'b0}}};

    assign lk.refillEn = state == sRefill && memRespValid && !flush;
    assign lk.cancel   = flush || state == sRecover;

    always_ff @(posedge clk) begin
        if (rst) begin
            lk.lookupValid <= 1'b0;
        end else begin
            lk.lookupValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lk.lookupAddr <= fetchAddr;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            sRunning: begin
                if (missNow) begin
                    nextState = sRefill;
                end
            end
            sRefill: begin
                // a response together with flush is simply dropped
                if (memRespValid) begin
                    nextState = sRunning;
                end else if (flush) begin
                    nextState = sRecover;
                end
            end
            sRecover: begin
                if (memRespValid) begin
                    nextState = sRunning;
                end
            end
            default: begin
                nextState = sRunning;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sRunning;
        end else begin
            state <= nextState;
        end
    end

    // only one line request per miss
    assert property (@(posedge clk) disable iff (rst)
        memReqValid |=> !memReqValid);

endmodule

// File: rtl/setStore.sv
`timescale 1ns/1ps

module setStore #(
    parameter int INDEX_BITS = 6,
    parameter type payloadT = logic
) (
    input  logic                   clk,
    input  logic [INDEX_BITS-1:0]  readIndex,
    input  logic                   writeEn,
    input  icachePkg::wayT         writeWay,
    input  logic [INDEX_BITS-1:0]  writeIndex,
    input  payloadT                writeData,
    output payloadT                readData [icachePkg::NUM_WAYS]
);

    localparam int NUM_SETS = 2 ** INDEX_BITS;

    // one array per way, all read together, written one way at a time
    for (genvar w = 0; w < icachePkg::NUM_WAYS; w++) begin : g_way
        payloadT mem [NUM_SETS];

        always_ff @(posedge clk) begin
            if (writeEn && writeWay == icachePkg::wayT'(w)) begin
                mem[writeIndex] <= writeData;
            end
            readData[w] <= mem[readIndex];
        end
    end

endmodule

// File: rtl/lookupIf.sv
`timescale 1ns/1ps

interface lookupIf;

    // a lookup result is due this cycle
    logic lookupValid;

    // registered request address of the lookup or refill in progress
    icachePkg::addrT lookupAddr;

    // memory line arrived and the refill was not cancelled
    logic refillEn;

    // flush or recover, no instruction output this cycle
    logic cancel;

    // some valid way holds the lookup line
    logic hit;

    modport front (
        output lookupValid,
        output lookupAddr,
        output refillEn,
        output cancel,
        input  hit
    );

    modport lookup (
        input  lookupValid,
        input  lookupAddr,
        input  refillEn,
        input  cancel,
        output hit
    );

endinterface

// File: rtl/icachePkg.sv
package icachePkg;

    // fetch and memory address width
    localparam int ADDR_BITS = 32;

    // byte offset inside one 16-byte line
    localparam int OFFSET_BITS = 4;

    // the age tree below is written for exactly four ways
    localparam int NUM_WAYS = 4;

    localparam int WORD_BITS = 32;

    // bits of a whole line, derived from the byte offset
    localparam int LINE_BITS = (2 ** OFFSET_BITS) * 8;

    typedef logic [ADDR_BITS-1:0] addrT;

    typedef logic [WORD_BITS-1:0] instT;

    // four instruction words, word 0 in the low bits
    typedef logic [LINE_BITS-1:0] lineT;

    // full line address is kept as the tag, so any index width works
    typedef logic [ADDR_BITS-OFFSET_BITS-1:0] lineTagT;

    typedef logic [$clog2(NUM_WAYS)-1:0] wayT;

    // tree pseudo-LRU state of one set
    // bit0 picks the half, bit1 covers ways 0/1, bit2 covers ways 2/3
    typedef logic [NUM_WAYS-2:0] ageT;

endpackage
